// File: hw/lsq_pkg.sv
package lsq_pkg;

    // ==================================================
    // Sizes
    // ==================================================
    localparam int ROB_DEPTH  = 32;
    localparam int SQ_DEPTH   = 8;
    localparam int LQ_DEPTH   = 8;
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;

    // Derived widths
    localparam int ROB_IDX_WIDTH  = $clog2(ROB_DEPTH);
    localparam int SQ_PTR_WIDTH   = $clog2(SQ_DEPTH);
    localparam int LQ_PTR_WIDTH   = $clog2(LQ_DEPTH);
    // Counts must reach the full depth
    localparam int SQ_COUNT_WIDTH = $clog2(SQ_DEPTH + 1);
    localparam int LQ_COUNT_WIDTH = $clog2(LQ_DEPTH + 1);

    // ==================================================
    // Vector types
    // ==================================================
    typedef logic [ROB_IDX_WIDTH-1:0]  rob_idx_t;
    typedef logic [ADDR_WIDTH-1:0]     addr_t;
    typedef logic [DATA_WIDTH-1:0]     data_t;
    // Slot pointers wrap at the queue depth
    typedef logic [SQ_PTR_WIDTH-1:0]   sq_ptr_t;
    typedef logic [LQ_PTR_WIDTH-1:0]   lq_ptr_t;
    typedef logic [SQ_COUNT_WIDTH-1:0] sq_count_t;
    typedef logic [LQ_COUNT_WIDTH-1:0] lq_count_t;

    // ==================================================
    // Bus state machines
    // ==================================================
    // Store drain, one write in flight
    typedef enum logic [0:0] {
        SQ_IDLE,
        SQ_WRITE
    } sq_drain_state_e;

    // Load issue, read then one writeback cycle
    typedef enum logic [1:0] {
        LQ_IDLE,
        LQ_READ,
        LQ_WRITEBACK
    } lq_issue_state_e;

endpackage

// File: hw/lsq_dispatch.sv
`timescale 1ns/1ns

module lsq_dispatch (
    input  logic              clock,
    input  logic              reset,
    input  logic              dispatch_valid_i,
    input  logic              dispatch_is_store_i,
    input  lsq_pkg::rob_idx_t dispatch_rob_idx_i,
    input  logic              sq_full_i,
    input  logic              lq_full_i,
    output logic              sq_enq_o,
    output logic              lq_enq_o,
    output logic              lsq_full_o
);
    import lsq_pkg::*;

    // Last accepted ROB index
    rob_idx_t last_rob_idx_q;
    // Nothing accepted since reset yet
    logic     last_seen_q;
    logic     new_dispatch;

    // Repeat of the last accepted index is dropped
    assign new_dispatch = dispatch_valid_i &&
                          (!last_seen_q || (dispatch_rob_idx_i != last_rob_idx_q));

    // Stall follows the queue this instruction targets
    assign lsq_full_o = dispatch_is_store_i ? sq_full_i : lq_full_i;

    // Steer by kind, blocked while the target is full
    assign sq_enq_o = new_dispatch && dispatch_is_store_i && !sq_full_i;
    assign lq_enq_o = new_dispatch && !dispatch_is_store_i && !lq_full_i;

    // Record only accepted dispatches
    // A stalled instruction stays eligible on retry
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            last_seen_q    <= 1'b0;
            last_rob_idx_q <= '0;
        end else if (sq_enq_o || lq_enq_o) begin
            last_seen_q    <= 1'b1;
            last_rob_idx_q <= dispatch_rob_idx_i;
        end
    end

endmodule

// File: hw/lsq_store_queue.sv
`timescale 1ns/1ns

module lsq_store_queue (
    input  logic              clock,
    input  logic              reset,
    // Enqueue from dispatch
    input  logic              sq_enq_i,
    input  lsq_pkg::rob_idx_t enq_rob_idx_i,
    output logic              sq_full_o,
    // Execute fill
    input  logic              exec_valid_i,
    input  lsq_pkg::rob_idx_t exec_rob_idx_i,
    input  lsq_pkg::addr_t    exec_addr_i,
    input  lsq_pkg::data_t    exec_data_i,
    // Commit from ROB
    input  logic              commit_valid_i,
    input  lsq_pkg::rob_idx_t commit_rob_idx_i,
    // Ready report to ROB
    output logic              rob_store_ready_valid_o,
    output lsq_pkg::rob_idx_t rob_store_ready_idx_o,
    // Wishbone write master
    output logic              st_cyc_o,
    output logic              st_stb_o,
    output lsq_pkg::addr_t    st_adr_o,
    output lsq_pkg::data_t    st_dat_o,
    input  logic              st_ack_i
);
    import lsq_pkg::*;

    // ==================================================
    // Entry storage
    // ==================================================
    // Per-slot flags
    logic [SQ_DEPTH-1:0] valid_q;
    logic [SQ_DEPTH-1:0] filled_q;
    logic [SQ_DEPTH-1:0] committed_q;
    // Payload
    rob_idx_t rob_idx_q [SQ_DEPTH];
    addr_t    addr_q    [SQ_DEPTH];
    data_t    data_q    [SQ_DEPTH];

    sq_ptr_t   head_q;
    sq_ptr_t   tail_q;
    sq_count_t count_q;

    sq_drain_state_e state_q;
    sq_drain_state_e state_d;

    logic    exec_hit;
    sq_ptr_t exec_slot;
    logic    commit_hit;
    sq_ptr_t commit_slot;
    logic    head_ready;
    logic    drain_done;

    assign sq_full_o = (count_q == sq_count_t'(SQ_DEPTH));

    // Execute match, only entries still waiting for data
    always_comb begin
        exec_hit  = 1'b0;
        exec_slot = '0;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            if (exec_valid_i && valid_q[i] && !filled_q[i] &&
                (rob_idx_q[i] == exec_rob_idx_i)) begin
                exec_hit  = 1'b1;
                exec_slot = sq_ptr_t'(i);
            end
        end
    end

    // Commit match
    always_comb begin
        commit_hit  = 1'b0;
        commit_slot = '0;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            if (commit_valid_i && valid_q[i] && (rob_idx_q[i] == commit_rob_idx_i)) begin
                commit_hit  = 1'b1;
                commit_slot = sq_ptr_t'(i);
            end
        end
    end

    // ==================================================
    // Drain FSM
    // ==================================================
    // Head may go out once it has data and is committed
    assign head_ready = valid_q[head_q] && filled_q[head_q] && committed_q[head_q];

    always_comb begin
        state_d    = state_q;
        drain_done = 1'b0;
        case (state_q)
            SQ_IDLE: begin
                if (head_ready) begin
                    state_d = SQ_WRITE;
                end
            end
            SQ_WRITE: begin
                // Slave ack ends the cycle and frees the head
                if (st_ack_i) begin
                    drain_done = 1'b1;
                    state_d    = SQ_IDLE;
                end
            end
            default: state_d = SQ_IDLE;
        endcase
    end

    // Bus outputs held from the head slot for the whole cycle
    assign st_cyc_o = (state_q == SQ_WRITE);
    assign st_stb_o = (state_q == SQ_WRITE);
    assign st_adr_o = addr_q[head_q];
    assign st_dat_o = data_q[head_q];

    // Control state
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_q                 <= '0;
            filled_q                <= '0;
            committed_q             <= '0;
            head_q                  <= '0;
            tail_q                  <= '0;
            count_q                 <= '0;
            state_q                 <= SQ_IDLE;
            rob_store_ready_valid_o <= 1'b0;
            rob_store_ready_idx_o   <= '0;
        end else begin
            if (sq_enq_i) begin
                valid_q[tail_q]     <= 1'b1;
                filled_q[tail_q]    <= 1'b0;
                committed_q[tail_q] <= 1'b0;
                tail_q              <= tail_q + 1'b1;
            end
            if (exec_hit) begin
                filled_q[exec_slot] <= 1'b1;
            end
            if (commit_hit) begin
                committed_q[commit_slot] <= 1'b1;
            end
            if (drain_done) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= head_q + 1'b1;
            end
            count_q <= count_q + sq_count_t'(sq_enq_i) - sq_count_t'(drain_done);
            state_q <= state_d;
            // One-cycle ready pulse after the execute write
            rob_store_ready_valid_o <= exec_hit;
            rob_store_ready_idx_o   <= exec_rob_idx_i;
        end
    end

    // Payload writes
    always_ff @(posedge clock) begin
        if (sq_enq_i) begin
            rob_idx_q[tail_q] <= enq_rob_idx_i;
        end
        if (exec_hit) begin
            addr_q[exec_slot] <= exec_addr_i;
            data_q[exec_slot] <= exec_data_i;
        end
    end

endmodule

// File: hw/lsq_load_queue.sv
`timescale 1ns/1ns

module lsq_load_queue (
    input  logic              clock,
    input  logic              reset,
    // Enqueue from dispatch
    input  logic              lq_enq_i,
    input  lsq_pkg::rob_idx_t enq_rob_idx_i,
    output logic              lq_full_o,
    // Address from execute
    input  logic              exec_valid_i,
    input  lsq_pkg::rob_idx_t exec_rob_idx_i,
    input  lsq_pkg::addr_t    exec_addr_i,
    // Wishbone read master
    output logic              ld_cyc_o,
    output logic              ld_stb_o,
    output lsq_pkg::addr_t    ld_adr_o,
    input  logic              ld_ack_i,
    input  lsq_pkg::data_t    ld_dat_i,
    // Writeback
    output logic              wb_valid_o,
    output lsq_pkg::rob_idx_t wb_rob_idx_o,
    output lsq_pkg::data_t    wb_data_o
);
    import lsq_pkg::*;

    // ==================================================
    // Entry storage
    // ==================================================
    logic [LQ_DEPTH-1:0] valid_q;
    logic [LQ_DEPTH-1:0] addr_valid_q;
    rob_idx_t rob_idx_q [LQ_DEPTH];
    addr_t    addr_q    [LQ_DEPTH];

    lq_ptr_t   head_q;
    lq_ptr_t   tail_q;
    lq_count_t count_q;

    lq_issue_state_e state_q;
    lq_issue_state_e state_d;

    // Read data held for the writeback cycle
    data_t   ld_data_q;

    logic    exec_hit;
    lq_ptr_t exec_slot;
    logic    head_ready;
    logic    capture;
    logic    retire;

    assign lq_full_o = (count_q == lq_count_t'(LQ_DEPTH));

    // Address match, entries without an address yet
    always_comb begin
        exec_hit  = 1'b0;
        exec_slot = '0;
        for (int i = 0; i < LQ_DEPTH; i++) begin
            if (exec_valid_i && valid_q[i] && !addr_valid_q[i] &&
                (rob_idx_q[i] == exec_rob_idx_i)) begin
                exec_hit  = 1'b1;
                exec_slot = lq_ptr_t'(i);
            end
        end
    end

    // ==================================================
    // Issue FSM
    // ==================================================
    // In-order issue, only the head can go
    assign head_ready = valid_q[head_q] && addr_valid_q[head_q];

    always_comb begin
        state_d = state_q;
        capture = 1'b0;
        retire  = 1'b0;
        case (state_q)
            LQ_IDLE: begin
                if (head_ready) begin
                    state_d = LQ_READ;
                end
            end
            LQ_READ: begin
                // Data valid with ack
                if (ld_ack_i) begin
                    capture = 1'b1;
                    state_d = LQ_WRITEBACK;
                end
            end
            LQ_WRITEBACK: begin
                // Entry leaves at the end of the writeback cycle
                retire  = 1'b1;
                state_d = LQ_IDLE;
            end
            default: state_d = LQ_IDLE;
        endcase
    end

    assign ld_cyc_o = (state_q == LQ_READ);
    assign ld_stb_o = (state_q == LQ_READ);
    assign ld_adr_o = addr_q[head_q];

    // Head still points at the load until it retires
    assign wb_valid_o   = (state_q == LQ_WRITEBACK);
    assign wb_rob_idx_o = rob_idx_q[head_q];
    assign wb_data_o    = ld_data_q;

    // Control state
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_q      <= '0;
            addr_valid_q <= '0;
            head_q       <= '0;
            tail_q       <= '0;
            count_q      <= '0;
            state_q      <= LQ_IDLE;
        end else begin
            if (lq_enq_i) begin
                valid_q[tail_q]      <= 1'b1;
                addr_valid_q[tail_q] <= 1'b0;
                tail_q               <= tail_q + 1'b1;
            end
            if (exec_hit) begin
                addr_valid_q[exec_slot] <= 1'b1;
            end
            if (retire) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= head_q + 1'b1;
            end
            count_q <= count_q + lq_count_t'(lq_enq_i) - lq_count_t'(retire);
            state_q <= state_d;
        end
    end

    // Payload writes
    always_ff @(posedge clock) begin
        if (lq_enq_i) begin
            rob_idx_q[tail_q] <= enq_rob_idx_i;
        end
        if (exec_hit) begin
            addr_q[exec_slot] <= exec_addr_i;
        end
        if (capture) begin
            ld_data_q <= ld_dat_i;
        end
    end

endmodule

// File: hw/lsq_top.sv
`timescale 1ns/1ns

module lsq_top (
    input  logic              clock,
    input  logic              reset,

    // ==================================================
    // Dispatch
    // ==================================================
    input  logic              dispatch_valid_i,
    input  logic              dispatch_is_store_i,
    input  lsq_pkg::rob_idx_t dispatch_rob_idx_i,
    output logic              lsq_full_o,

    // Execute results, address and store data
    input  logic              exec_valid_i,
    input  lsq_pkg::rob_idx_t exec_rob_idx_i,
    input  lsq_pkg::addr_t    exec_addr_i,
    input  lsq_pkg::data_t    exec_data_i,

    // Commit
    input  logic              commit_valid_i,
    input  lsq_pkg::rob_idx_t commit_rob_idx_i,

    // ==================================================
    // Results to ROB
    // ==================================================
    output logic              wb_valid_o,
    output lsq_pkg::rob_idx_t wb_rob_idx_o,
    output lsq_pkg::data_t    wb_data_o,
    output logic              rob_store_ready_valid_o,
    output lsq_pkg::rob_idx_t rob_store_ready_idx_o,

    // ==================================================
    // Wishbone ports
    // ==================================================
    // Store port, write only
    output logic              st_cyc_o,
    output logic              st_stb_o,
    output lsq_pkg::addr_t    st_adr_o,
    output lsq_pkg::data_t    st_dat_o,
    input  logic              st_ack_i,
    // Load port, read only
    output logic              ld_cyc_o,
    output logic              ld_stb_o,
    output lsq_pkg::addr_t    ld_adr_o,
    input  logic              ld_ack_i,
    input  lsq_pkg::data_t    ld_dat_i
);

    // Queue status back to dispatch
    logic sq_full;
    logic lq_full;
    // Steered enqueue strobes
    logic sq_enq;
    logic lq_enq;

    lsq_dispatch dispatch_i (
        .clock               (clock),
        .reset               (reset),
        .dispatch_valid_i    (dispatch_valid_i),
        .dispatch_is_store_i (dispatch_is_store_i),
        .dispatch_rob_idx_i  (dispatch_rob_idx_i),
        .sq_full_i           (sq_full),
        .lq_full_i           (lq_full),
        .sq_enq_o            (sq_enq),
        .lq_enq_o            (lq_enq),
        .lsq_full_o          (lsq_full_o)
    );

    lsq_store_queue store_queue_i (
        .clock                   (clock),
        .reset                   (reset),
        .sq_enq_i                (sq_enq),
        .enq_rob_idx_i           (dispatch_rob_idx_i),
        .sq_full_o               (sq_full),
        .exec_valid_i            (exec_valid_i),
        .exec_rob_idx_i          (exec_rob_idx_i),
        .exec_addr_i             (exec_addr_i),
        .exec_data_i             (exec_data_i),
        .commit_valid_i          (commit_valid_i),
        .commit_rob_idx_i        (commit_rob_idx_i),
        .rob_store_ready_valid_o (rob_store_ready_valid_o),
        .rob_store_ready_idx_o   (rob_store_ready_idx_o),
        .st_cyc_o                (st_cyc_o),
        .st_stb_o                (st_stb_o),
        .st_adr_o                (st_adr_o),
        .st_dat_o                (st_dat_o),
        .st_ack_i                (st_ack_i)
    );

    // Load side sees the same execute bus, without the data
    lsq_load_queue load_queue_i (
        .clock          (clock),
        .reset          (reset),
        .lq_enq_i       (lq_enq),
        .enq_rob_idx_i  (dispatch_rob_idx_i),
        .lq_full_o      (lq_full),
        .exec_valid_i   (exec_valid_i),
        .exec_rob_idx_i (exec_rob_idx_i),
        .exec_addr_i    (exec_addr_i),
        .ld_cyc_o       (ld_cyc_o),
        .ld_stb_o       (ld_stb_o),
        .ld_adr_o       (ld_adr_o),
        .ld_ack_i       (ld_ack_i),
        .ld_dat_i       (ld_dat_i),
        .wb_valid_o     (wb_valid_o),
        .wb_rob_idx_o   (wb_rob_idx_o),
        .wb_data_o      (wb_data_o)
    );

endmodule

// File: bench/lsq_checker.sv
`timescale 1ns/1ns

module lsq_checker (
    input  logic           clock,
    input  logic           reset,
    input  logic           st_cyc_i,
    input  logic           st_stb_i,
    input  lsq_pkg::addr_t st_adr_i,
    input  lsq_pkg::data_t st_dat_i,
    input  logic           st_ack_i,
    input  logic           ld_cyc_i,
    input  logic           ld_stb_i,
    input  lsq_pkg::addr_t ld_adr_i,
    input  logic           ld_ack_i,
    input  logic           wb_valid_i
);

    // ==================================================
    // Wishbone classic rules
    // ==================================================
    st_stb_in_cyc: assert property (@(posedge clock) disable iff (reset) st_stb_i |-> st_cyc_i)
        else $error("store port strobe without cycle");
    ld_stb_in_cyc: assert property (@(posedge clock) disable iff (reset) ld_stb_i |-> ld_cyc_i)
        else $error("load port strobe without cycle");

    // Request held unchanged until the slave acks
    st_hold: assert property (@(posedge clock) disable iff (reset)
        (st_stb_i && !st_ack_i) |=> (st_stb_i && $stable(st_adr_i) && $stable(st_dat_i)))
        else $error("store request changed before ack");
    ld_hold: assert property (@(posedge clock) disable iff (reset)
        (ld_stb_i && !ld_ack_i) |=> (ld_stb_i && $stable(ld_adr_i)))
        else $error("load request changed before ack");

    // Writeback is a lone pulse
    wb_single: assert property (@(posedge clock) disable iff (reset) wb_valid_i |=> !wb_valid_i)
        else $error("writeback valid high in two consecutive cycles");

endmodule

bind lsq_top lsq_checker checker_i (
    .clock      (clock),
    .reset      (reset),
    .st_cyc_i   (st_cyc_o),
    .st_stb_i   (st_stb_o),
    .st_adr_i   (st_adr_o),
    .st_dat_i   (st_dat_o),
    .st_ack_i   (st_ack_i),
    .ld_cyc_i   (ld_cyc_o),
    .ld_stb_i   (ld_stb_o),
    .ld_adr_i   (ld_adr_o),
    .ld_ack_i   (ld_ack_i),
    .wb_valid_i (wb_valid_o)
);

// File: bench/lsq_tb.sv
`timescale 1ns/1ns

module lsq_tb;
    import lsq_pkg::*;

    localparam int NUM_ROWS    = 12;
    localparam int NUM_STORES  = 8;
    localparam int NUM_LOADS   = 4;
    localparam int CYCLE_LIMIT = NUM_ROWS * 20 + 100;

    logic     clock = 1'b0;
    logic     reset;
    logic     dispatch_valid_i;
    logic     dispatch_is_store_i;
    rob_idx_t dispatch_rob_idx_i;
    logic     lsq_full_o;
    logic     exec_valid_i;
    rob_idx_t exec_rob_idx_i;
    addr_t    exec_addr_i;
    data_t    exec_data_i;
    logic     commit_valid_i;
    rob_idx_t commit_rob_idx_i;
    logic     wb_valid_o;
    rob_idx_t wb_rob_idx_o;
    data_t    wb_data_o;
    logic     rob_store_ready_valid_o;
    rob_idx_t rob_store_ready_idx_o;
    logic     st_cyc_o;
    logic     st_stb_o;
    addr_t    st_adr_o;
    data_t    st_dat_o;
    logic     st_ack_i;
    logic     ld_cyc_o;
    logic     ld_stb_o;
    addr_t    ld_adr_o;
    logic     ld_ack_i;
    data_t    ld_dat_i;

    // Operation table columns are kind, ROB index, address, data and twice flag
    bit       row_is_store [NUM_ROWS];
    rob_idx_t row_rob      [NUM_ROWS];
    addr_t    row_addr     [NUM_ROWS];
    data_t    row_data     [NUM_ROWS];
    bit       row_twice    [NUM_ROWS];
    bit       exec_done    [NUM_ROWS];
    int       exec_order   [NUM_ROWS];
    int       store_rows[$];
    int       load_rows[$];
    int       ack_wait[64];

    // Observed traffic
    rob_idx_t ready_q[$];
    rob_idx_t exec_store_q[$];
    rob_idx_t wb_idx_q[$];
    data_t    wb_data_q[$];
    addr_t    st_adr_q[$];
    data_t    st_dat_q[$];
    int       st_commits_q[$];
    addr_t    ld_adr_q[$];
    bit       ld_exec_ok_q[$];
    data_t    mem [addr_t];

    int       errors = 0;
    int       checks = 0;
    int       tests_run = 0;
    int       tests_failed = 0;
    int       test_start_errors = 0;
    int       cycle_count = 0;
    int       commits_done = 0;
    int       stores_seen;
    int       match_count;
    int       pick;
    int       swap;
    logic     full_for_store;
    logic     full_for_load;

    lsq_top dut_i (.*);

    always #20 clock = ~clock;

    // Run limit
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("Regression failed");
            $finish;
        end
    end

    // Word for an address never written mixes every address bit
    function automatic data_t fill_word(input addr_t a);
        return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b1);
    endfunction

    function automatic data_t mem_read(input addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return fill_word(a);
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors > test_start_errors) begin
            tests_failed++;
            $display("Test %-14s FAILED, %0d errors", name, errors - test_start_errors);
        end else begin
            $display("Test %-14s ok", name);
        end
        test_start_errors = errors;
    endtask

    task automatic set_row(input int r, input bit st, input rob_idx_t rob, input addr_t a,
                           input data_t d, input bit twice);
        row_is_store[r] = st;
        row_rob[r]      = rob;
        row_addr[r]     = a;
        // Load addresses never hit a store so the fill word is expected
        row_data[r]     = st ? d : fill_word(a);
        row_twice[r]    = twice;
        if (st) begin
            store_rows.push_back(r);
        end else begin
            load_rows.push_back(r);
        end
    endtask

    task automatic build_table();
        set_row(0,  1, 5'd5,  32'h0000_1000, 32'hdead_0001, 0);
        set_row(1,  1, 5'd9,  32'h0000_1004, 32'hbeef_0002, 1);
        set_row(2,  0, 5'd10, 32'h0000_2040, 32'h0, 0);
        set_row(3,  1, 5'd11, 32'h0000_1008, 32'h1234_5678, 0);
        set_row(4,  1, 5'd14, 32'h0000_100c, 32'h0bad_cafe, 0);
        set_row(5,  0, 5'd15, 32'h0000_2044, 32'h0, 1);
        set_row(6,  1, 5'd17, 32'h0000_1010, 32'hc001_d00d, 0);
        set_row(7,  1, 5'd20, 32'h0000_1014, 32'h5555_aaaa, 0);
        set_row(8,  1, 5'd22, 32'h0000_1018, 32'h0f0f_f0f0, 0);
        set_row(9,  1, 5'd25, 32'h0000_101c, 32'h8000_0001, 0);
        // Loads behind a full store queue
        set_row(10, 0, 5'd27, 32'h0000_3100, 32'h0, 0);
        set_row(11, 0, 5'd30, 32'h8000_0ffc, 32'h0, 0);
    endtask

    // Twice rows repeat the same index on the next cycle
    task automatic dispatch_row(input int r);
        @(posedge clock);
        dispatch_valid_i    <= 1'b1;
        dispatch_is_store_i <= row_is_store[r];
        dispatch_rob_idx_i  <= row_rob[r];
        if (row_twice[r]) begin
            @(posedge clock);
        end
        @(posedge clock);
        dispatch_valid_i <= 1'b0;
    endtask

    // Stall flag seen for each kind while idle
    task automatic probe_full();
        @(posedge clock);
        dispatch_is_store_i <= 1'b1;
        @(negedge clock);
        full_for_store = lsq_full_o;
        @(posedge clock);
        dispatch_is_store_i <= 1'b0;
        @(negedge clock);
        full_for_load = lsq_full_o;
    endtask

    task automatic execute_row(input int r);
        @(posedge clock);
        exec_valid_i   <= 1'b1;
        exec_rob_idx_i <= row_rob[r];
        exec_addr_i    <= row_addr[r];
        exec_data_i    <= row_is_store[r] ? row_data[r] : '0;
        @(posedge clock);
        exec_valid_i <= 1'b0;
        // DUT took the address at this edge
        exec_done[r] = 1'b1;
        if (row_is_store[r]) begin
            exec_store_q.push_back(row_rob[r]);
        end
    endtask

    task automatic commit_row(input int r);
        @(posedge clock);
        commit_valid_i   <= 1'b1;
        commit_rob_idx_i <= row_rob[r];
        @(posedge clock);
        commit_valid_i <= 1'b0;
        commits_done++;
    endtask

    // ==================================================
    // Bus slaves and monitors
    // ==================================================
    // Store slave sees the request mid-cycle and acks after a random wait
    initial begin
        forever begin
            @(negedge clock);
            if (!reset && st_cyc_o && st_stb_o) begin
                pick = ack_wait[st_adr_q.size() % 32];
                st_adr_q.push_back(st_adr_o);
                st_dat_q.push_back(st_dat_o);
                st_commits_q.push_back(commits_done);
                repeat (pick) @(posedge clock);
                @(posedge clock);
                st_ack_i <= 1'b1;
                mem[st_adr_o] = st_dat_o;
                @(posedge clock);
                st_ack_i <= 1'b0;
            end
        end
    end

    // Load slave drives data valid with ack
    initial begin
        forever begin
            @(negedge clock);
            if (!reset && ld_cyc_o && ld_stb_o) begin
                swap = ld_adr_q.size();
                ld_exec_ok_q.push_back((swap < NUM_LOADS) ? exec_done[load_rows[swap]] : 1'b0);
                ld_adr_q.push_back(ld_adr_o);
                repeat (ack_wait[32 + swap % 32]) @(posedge clock);
                @(posedge clock);
                ld_ack_i <= 1'b1;
                ld_dat_i <= mem_read(ld_adr_o);
                @(posedge clock);
                ld_ack_i <= 1'b0;
                ld_dat_i <= '0;
            end
        end
    end

    always @(negedge clock) begin
        if (!reset && rob_store_ready_valid_o) begin
            ready_q.push_back(rob_store_ready_idx_o);
        end
        if (!reset && wb_valid_o) begin
            wb_idx_q.push_back(wb_rob_idx_o);
            wb_data_q.push_back(wb_data_o);
        end
    end

    // ==================================================
    // Sequence
    // ==================================================
    initial begin
        void'($urandom(32'h7a9c_77bc));
        reset               = 1'b1;
        dispatch_valid_i    = 1'b0;
        dispatch_is_store_i = 1'b0;
        dispatch_rob_idx_i  = '0;
        exec_valid_i        = 1'b0;
        exec_rob_idx_i      = '0;
        exec_addr_i         = '0;
        exec_data_i         = '0;
        commit_valid_i      = 1'b0;
        commit_rob_idx_i    = '0;
        st_ack_i            = 1'b0;
        ld_ack_i            = 1'b0;
        ld_dat_i            = '0;
        build_table();
        for (int i = 0; i < 64; i++) begin
            ack_wait[i] = $urandom % 4;
        end
        // Shuffled execute order
        for (int i = 0; i < NUM_ROWS; i++) begin
            exec_order[i] = i;
        end
        for (int i = NUM_ROWS - 1; i > 0; i--) begin
            pick          = $urandom % (i + 1);
            swap          = exec_order[i];
            exec_order[i] = exec_order[pick];
            exec_order[pick] = swap;
        end

        repeat (3) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_value(st_cyc_o, 0, "st_cyc_o after reset");
        check_value(st_stb_o, 0, "st_stb_o after reset");
        check_value(ld_cyc_o, 0, "ld_cyc_o after reset");
        check_value(ld_stb_o, 0, "ld_stb_o after reset");
        check_value(wb_valid_o, 0, "wb_valid_o after reset");
        check_value(rob_store_ready_valid_o, 0, "ready valid after reset");
        check_value(lsq_full_o, 0, "lsq_full_o after reset");
        end_test("reset");

        stores_seen = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            dispatch_row(r);
            stores_seen += row_is_store[r];
            // Store queue just filled with nothing committed
            if (row_is_store[r] && stores_seen == SQ_DEPTH) begin
                probe_full();
            end
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            execute_row(exec_order[i]);
        end
        for (int k = 0; k < store_rows.size(); k++) begin
            commit_row(store_rows[k]);
        end
        while (st_adr_q.size() < NUM_STORES || wb_idx_q.size() < NUM_LOADS) begin
            @(posedge clock);
        end
        // Room for any extra pulse
        repeat (10) @(posedge clock);

        check_value(wb_idx_q.size(), NUM_LOADS, "writeback count");
        for (int k = 0; k < wb_idx_q.size() && k < NUM_LOADS; k++) begin
            check_value(wb_idx_q[k], row_rob[load_rows[k]], "writeback ROB index");
            check_value(wb_data_q[k], row_data[load_rows[k]], "writeback data");
            check_value(ld_adr_q[k], row_addr[load_rows[k]], "load bus address");
            check_value(ld_exec_ok_q[k], 1, "load issued before its address");
        end
        end_test("loads");

        check_value(ready_q.size(), NUM_STORES, "ready pulse count");
        for (int k = 0; k < ready_q.size() && k < exec_store_q.size(); k++) begin
            check_value(ready_q[k], exec_store_q[k], "ready index in execute order");
        end
        end_test("store ready");

        check_value(st_adr_q.size(), NUM_STORES, "store write count");
        for (int k = 0; k < st_adr_q.size() && k < NUM_STORES; k++) begin
            check_value(st_adr_q[k], row_addr[store_rows[k]], "store bus address");
            check_value(st_dat_q[k], row_data[store_rows[k]], "store bus data");
            check_value(st_commits_q[k] > k, 1, "store write before its commit");
            check_value(mem_read(row_addr[store_rows[k]]), row_data[store_rows[k]],
                        "memory after drain");
        end
        end_test("store drain");

        check_value(full_for_store, 1, "lsq_full_o for a store at 8 stores");
        check_value(full_for_load, 0, "lsq_full_o for a load at 8 stores");
        match_count = 0;
        foreach (ready_q[k]) begin
            match_count += (ready_q[k] == row_rob[1]);
        end
        check_value(match_count, 1, "ready pulses for repeated store");
        match_count = 0;
        foreach (st_adr_q[k]) begin
            match_count += (st_adr_q[k] == row_addr[1]);
        end
        check_value(match_count, 1, "bus writes for repeated store");
        match_count = 0;
        foreach (wb_idx_q[k]) begin
            match_count += (wb_idx_q[k] == row_rob[5]);
        end
        check_value(match_count, 1, "writebacks for repeated load");
        end_test("full and filter");

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: lsq.f
hw/lsq_pkg.sv
hw/lsq_dispatch.sv
hw/lsq_store_queue.sv
hw/lsq_load_queue.sv
hw/lsq_top.sv
bench/lsq_checker.sv
bench/lsq_tb.sv

// File: Bender.yml
package:
  name: lsq

sources:
  # Design, package first
  - hw/lsq_pkg.sv
  - hw/lsq_dispatch.sv
  - hw/lsq_store_queue.sv
  - hw/lsq_load_queue.sv
  - hw/lsq_top.sv

  # Testbench and bound checker
  - target: test
    files:
      - bench/lsq_checker.sv
      - bench/lsq_tb.sv
